// ==== all.f ====
+incdir+hdl
hdl/rat_pkg.sv
hdl/rename_pkg.sv
hdl/rat_tile.sv
hdl/rat_read_stage.sv
hdl/rat_top.sv
testbench/rat_clock_gen.sv
testbench/rat_tb.sv

// ==== hdl/rat_defs.svh ====
// Widths and counts for the register alias table.
// Include wherever a width or port count is needed; the guard makes
// repeated includes harmless.
`ifndef RAT_DEFS_SVH
`define RAT_DEFS_SVH

// reorder-buffer tag and functional-unit code widths
`define RAT_TAG_W 9
`define RAT_FN_W 10

// read address, register or group slot
`define RAT_ADDR_W 6

// 4 tiles of 8 entries cover the 32 architectural registers
`define RAT_TILES 4
`define RAT_TILE_ENTRIES 8

`define RAT_READ_PORTS 3
`define RAT_WRITE_PORTS 2
`define RAT_RET_PORTS 2

`define RAT_FN_RESET 10'h200

`endif

// ==== hdl/rat_pkg.sv ====
// Types for the contents of the alias table and for its read address.
// Referenced by scoped name from the RTL and from the rename bundles.
`default_nettype none
`include "rat_defs.svh"

package rat_pkg;

  typedef logic [`RAT_TAG_W-1:0] rob_tag_t;
  typedef logic [`RAT_FN_W-1:0] funit_t;

  typedef struct packed {
    logic [$clog2(`RAT_TILES)-1:0] tile;
    logic [$clog2(`RAT_TILE_ENTRIES)-1:0] entry;
  } arch_reg_t;

  typedef struct packed {
    rob_tag_t tag;
    funit_t funit;
    logic retired;
  } map_entry_t;

  // mode 0 names a register
  typedef struct packed {
    logic mode;
    arch_reg_t areg;
  } reg_addr_t;

  // marker 2'b11 names a slot of the rename group, 2'b10 is reserved
  typedef struct packed {
    logic [1:0] marker;
    logic [`RAT_ADDR_W-3:0] slot;
  } dep_addr_t;

  typedef union packed {
    reg_addr_t reg_view;
    dep_addr_t dep_view;
  } rat_addr_t;

endpackage

`default_nettype wire

// ==== hdl/rat_read_stage.sv ====
// Read side of the alias table.
// Registers the read addresses while clk_en is high, sends the entry index
// to every tile, then picks the tile output or bypasses a rename port when
// the address names a slot of the current group.
`timescale 1ns/100ps
`default_nettype none
`include "rat_defs.svh"

module rat_read_stage (
  input logic clk,
  input logic rst,
  input logic clk_en,
  input rat_pkg::rat_addr_t read_addr [`RAT_READ_PORTS],
  input rename_pkg::rename_write_t writes [`RAT_WRITE_PORTS],
  input rat_pkg::map_entry_t tile_data [`RAT_TILES][`RAT_READ_PORTS],
  output logic [$clog2(`RAT_TILE_ENTRIES)-1:0] read_entry [`RAT_READ_PORTS],
  output rename_pkg::read_result_t results [`RAT_READ_PORTS]
);

  localparam logic [1:0] DEP_MARKER = 2'b11;
  localparam int SLOT_W = `RAT_ADDR_W - 2;

  rat_pkg::rat_addr_t addr_q [`RAT_READ_PORTS];

  // address is held during a stall
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int q = 0; q < `RAT_READ_PORTS; q++)
      begin
        addr_q[q] <= '0;
      end
    end
    else if (clk_en)
    begin
      for (int q = 0; q < `RAT_READ_PORTS; q++)
      begin
        addr_q[q] <= read_addr[q];
      end
    end
  end

  always_comb
  begin
    for (int q = 0; q < `RAT_READ_PORTS; q++)
    begin
      read_entry[q] = addr_q[q].reg_view.areg.entry;
    end
  end

  always_comb
  begin
    for (int q = 0; q < `RAT_READ_PORTS; q++)
    begin
      // reserved addresses fall through with all zeros
      results[q] = '0;
      if (!addr_q[q].reg_view.mode)
      begin
        results[q].entry = tile_data[addr_q[q].reg_view.areg.tile][q];
      end
      else if (addr_q[q].dep_view.marker == DEP_MARKER)
      begin
        results[q].is_dep = 1'b1;
        // slots past the last write port read as tag 0, funit 0
        for (int p = 0; p < `RAT_WRITE_PORTS; p++)
        begin
          if (addr_q[q].dep_view.slot == SLOT_W'(p))
          begin
            results[q].entry.tag = writes[p].tag;
            results[q].entry.funit = writes[p].funit;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rat_tile.sv ====
// One tile of eight alias table entries.
// Takes the rename writes and retires broadcast to all tiles, keeps the
// entries whose tile number matches TILE_INDEX, and returns one entry per
// read port from the shared registered entry index.
`timescale 1ns/100ps
`default_nettype none
`include "rat_defs.svh"

module rat_tile #(
  parameter int unsigned TILE_INDEX = 0
) (
  input logic clk,
  input logic rst,
  input logic clk_en,
  input rename_pkg::rename_write_t writes [`RAT_WRITE_PORTS],
  input rename_pkg::retire_req_t retires [`RAT_RET_PORTS],
  input logic retire_all,
  input logic [$clog2(`RAT_TILE_ENTRIES)-1:0] read_entry [`RAT_READ_PORTS],
  output rat_pkg::map_entry_t tile_data [`RAT_READ_PORTS]
);

  localparam int ENTRIES = `RAT_TILE_ENTRIES;
  localparam int ENTRY_W = $clog2(`RAT_TILE_ENTRIES);
  localparam int TILE_W = $clog2(`RAT_TILES);

  rat_pkg::map_entry_t entries [ENTRIES];
  rat_pkg::map_entry_t entries_nxt [ENTRIES];
  logic [ENTRIES-1:0] wr_hit;
  logic [ENTRIES-1:0] ret_hit;

  always_comb
  begin
    for (int e = 0; e < ENTRIES; e++)
    begin
      entries_nxt[e] = entries[e];
      wr_hit[e] = 1'b0;
      ret_hit[e] = 1'b0;

      // retire matches on the stored tag
      for (int r = 0; r < `RAT_RET_PORTS; r++)
      begin
        if (retires[r].valid && retires[r].tag == entries[e].tag)
        begin
          ret_hit[e] = 1'b1;
        end
      end

      // higher port is applied last, so it wins on a collision
      for (int p = 0; p < `RAT_WRITE_PORTS; p++)
      begin
        if (clk_en && writes[p].valid &&
            writes[p].dst.tile == TILE_W'(TILE_INDEX) &&
            writes[p].dst.entry == ENTRY_W'(e))
        begin
          wr_hit[e] = 1'b1;
          entries_nxt[e].tag = writes[p].tag;
          entries_nxt[e].funit = writes[p].funit;
        end
      end

      // a fresh rename clears retired unless retire_all is also up
      entries_nxt[e].retired = retire_all |
                               (~wr_hit[e] & (entries[e].retired | ret_hit[e]));
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int e = 0; e < ENTRIES; e++)
      begin
        entries[e].tag <= '0;
        entries[e].funit <= `RAT_FN_RESET;
        entries[e].retired <= 1'b1;
      end
    end
    else
    begin
      for (int e = 0; e < ENTRIES; e++)
      begin
        entries[e] <= entries_nxt[e];
      end
    end
  end

  // per-port read mux, no extra latency
  always_comb
  begin
    for (int q = 0; q < `RAT_READ_PORTS; q++)
    begin
      tile_data[q] = entries[read_entry[q]];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rat_top.sv ====
// Register alias table of the rename stage.
// Four tiles of eight mappings sit side by side behind one read stage.
// Rename writes go to every tile and to the read stage for the in-group
// bypass; results follow the address sampled at the last enabled edge.
`timescale 1ns/100ps
`default_nettype none
`include "rat_defs.svh"

module rat_top (
  input logic clk,
  input logic rst,
  input logic clk_en,
  input rename_pkg::rename_write_t writes [`RAT_WRITE_PORTS],
  input rename_pkg::retire_req_t retires [`RAT_RET_PORTS],
  input logic retire_all,
  input rat_pkg::rat_addr_t read_addr [`RAT_READ_PORTS],
  output rename_pkg::read_result_t results [`RAT_READ_PORTS]
);

  // shared entry index, one per read port
  logic [$clog2(`RAT_TILE_ENTRIES)-1:0] read_entry [`RAT_READ_PORTS];

  rat_pkg::map_entry_t tile_data [`RAT_TILES][`RAT_READ_PORTS];

  genvar t;
  generate
    for (t = 0; t < `RAT_TILES; t++)
    begin : g_tile
      rat_tile #(
        .TILE_INDEX(t)
      ) u_tile (
        .clk(clk),
        .rst(rst),
        .clk_en(clk_en),
        .writes(writes),
        .retires(retires),
        .retire_all(retire_all),
        .read_entry(read_entry),
        .tile_data(tile_data[t])
      );
    end
  endgenerate

  rat_read_stage u_read_stage (
    .clk(clk),
    .rst(rst),
    .clk_en(clk_en),
    .read_addr(read_addr),
    .writes(writes),
    .tile_data(tile_data),
    .read_entry(read_entry),
    .results(results)
  );

endmodule

`default_nettype wire

// ==== hdl/rename_pkg.sv ====
// Request and result bundles seen at the ports of the alias table.
// Rename writes, retire requests and read results each travel as one struct.
`default_nettype none

package rename_pkg;

  // one rename of dst to a new tag
  typedef struct packed {
    logic valid;
    rat_pkg::arch_reg_t dst;
    rat_pkg::rob_tag_t tag;
    rat_pkg::funit_t funit;
  } rename_write_t;

  // retire every mapping that holds this tag
  typedef struct packed {
    logic valid;
    rat_pkg::rob_tag_t tag;
  } retire_req_t;

  // is_dep marks a result taken from the current rename group
  typedef struct packed {
    rat_pkg::map_entry_t entry;
    logic is_dep;
  } read_result_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the alias table testbench with Verilator and runs it
# exit status is 0 only when the run reports no errors
cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module rat_tb -o rat_sim &&
./obj_dir/rat_sim | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "simulation passed" ||
{
  echo "simulation failed"
  exit 1
}

// ==== testbench/rat_clock_gen.sv ====
// Clock and reset source for the alias table testbench.
// Reset is high from time zero and drops after RESET_CYCLES rising edges.
`timescale 1ns/100ps
`default_nettype none

module rat_clock_gen #(
  parameter int PERIOD_NS = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    rst <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== testbench/rat_tb.sv ====
// Testbench for the register alias table.
// Drives renames, retires, stalls and group-slot reads on the falling edge,
// keeps a model of the 32 mappings and checks every read port just before
// each falling edge.
`timescale 1ns/100ps
`default_nettype none
`include "rat_defs.svh"

module rat_tb;

  localparam int CLK_PERIOD = 40;
  localparam int TEST_CYCLES = 180;
  localparam int NUM_REGS = `RAT_TILES * `RAT_TILE_ENTRIES;

  logic clk;
  logic rst;
  logic clk_en;
  logic retire_all;
  rename_pkg::rename_write_t writes [`RAT_WRITE_PORTS];
  rename_pkg::retire_req_t retires [`RAT_RET_PORTS];
  rat_pkg::rat_addr_t read_addr [`RAT_READ_PORTS];
  rename_pkg::read_result_t results [`RAT_READ_PORTS];

  // model of the table and of the addresses sampled by the DUT
  rat_pkg::map_entry_t model [NUM_REGS];
  rat_pkg::rat_addr_t addr_s [`RAT_READ_PORTS];
  int error_count = 0;
  int check_count = 0;

  rat_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) u_clock_gen (
    .clk(clk),
    .rst(rst)
  );

  rat_top UUT (
    .clk(clk),
    .rst(rst),
    .clk_en(clk_en),
    .writes(writes),
    .retires(retires),
    .retire_all(retire_all),
    .read_addr(read_addr),
    .results(results)
  );

  // tags come from a small pool so that several registers share one
  function automatic rename_pkg::rename_write_t random_write(input int unsigned valid_pct);
    rename_pkg::rename_write_t w;
    w.valid = ($urandom_range(99) < valid_pct);
    w.dst = 5'($urandom_range(NUM_REGS - 1));
    w.tag = `RAT_TAG_W'($urandom_range(15));
    w.funit = `RAT_FN_W'($urandom);
    return w;
  endfunction

  function automatic rename_pkg::read_result_t expected_result(
    input rat_pkg::map_entry_t table_in [NUM_REGS],
    input rat_pkg::rat_addr_t addr,
    input rename_pkg::rename_write_t cur_writes [`RAT_WRITE_PORTS]
  );
    rename_pkg::read_result_t res;
    logic [`RAT_ADDR_W-1:0] raw;
    res = '0;
    raw = addr;
    // 0 to 31 registers, 32 to 47 reserved, 48 to 63 group slots
    if (raw < 6'd32)
      res.entry = table_in[raw[4:0]];
    else if (raw >= 6'd48)
    begin
      res.is_dep = 1'b1;
      for (int p = 0; p < `RAT_WRITE_PORTS; p++)
      begin
        if (raw[3:0] == 4'(p))
        begin
          res.entry.tag = cur_writes[p].tag;
          res.entry.funit = cur_writes[p].funit;
        end
      end
    end
    return res;
  endfunction

  task automatic check_entry(input int port, input rat_pkg::map_entry_t got,
                             input rat_pkg::map_entry_t want);
    check_count++;
    if (got !== want)
    begin
      error_count++;
      $display("FAILED at %0d ns: port %0d read tag %h funit %h retired %b, %s %h %h %b",
               $time, port, got.tag, got.funit, got.retired, "expected",
               want.tag, want.funit, want.retired);
    end
  endtask

  task automatic check_dep(input int port, input logic got, input logic want);
    check_count++;
    if (got !== want)
    begin
      error_count++;
      $display("FAILED at %0d ns: port %0d is_dep %b, expected %b", $time, port, got, want);
    end
  endtask

  // model update at the same edge the DUT updates
  always @(posedge clk)
  begin
    rat_pkg::map_entry_t nxt;
    for (int r = 0; r < NUM_REGS; r++)
    begin
      nxt = model[r];
      for (int rr = 0; rr < `RAT_RET_PORTS; rr++)
      begin
        if (retires[rr].valid && retires[rr].tag == model[r].tag)
          nxt.retired = 1'b1;
      end
      // later port overwrites, so the higher index wins
      for (int p = 0; p < `RAT_WRITE_PORTS; p++)
      begin
        if (clk_en && writes[p].valid && writes[p].dst == 5'(r))
        begin
          nxt.tag = writes[p].tag;
          nxt.funit = writes[p].funit;
          nxt.retired = 1'b0;
        end
      end
      if (retire_all)
        nxt.retired = 1'b1;
      if (rst)
      begin
        nxt.tag = '0;
        nxt.funit = `RAT_FN_RESET;
        nxt.retired = 1'b1;
      end
      model[r] = nxt;
    end
    if (rst)
      addr_s = '{default: '0};
    else if (clk_en)
      addr_s = read_addr;
  end

  always @(negedge clk)
  begin
    rename_pkg::read_result_t want;
    for (int q = 0; q < `RAT_READ_PORTS; q++)
    begin
      want = expected_result(model, addr_s[q], writes);
      check_entry(q, results[q].entry, want.entry);
      check_dep(q, results[q].is_dep, want.is_dep);
    end
  end

  initial
  begin
    rename_pkg::rename_write_t w0;
    rename_pkg::rename_write_t w1;
    rename_pkg::retire_req_t r0;
    rename_pkg::retire_req_t r1;
    logic [4:0] k;
    void'($urandom(55583));
    clk_en <= 1'b1;
    retire_all <= 1'b0;
    writes <= '{default: '0};
    retires <= '{default: '0};
    read_addr <= '{default: '0};
    @(negedge rst);

    // reset values of all registers read three per cycle
    for (int i = 0; i < NUM_REGS; i += 3)
    begin
      @(negedge clk);
      for (int q = 0; q < `RAT_READ_PORTS; q++)
        read_addr[q] <= 6'((i + q) % NUM_REGS);
    end

    // renames read back at the same edge and later under random stalls
    for (int i = 0; i < 80; i++)
    begin
      @(negedge clk);
      w0 = random_write(80);
      w1 = random_write(80);
      if ($urandom_range(3) == 0)
        w1.dst = w0.dst;
      clk_en <= (i < 60) ? 1'b1 : 1'($urandom_range(1));
      writes[0] <= w0;
      writes[1] <= w1;
      read_addr[0] <= 6'(w0.dst);
      read_addr[1] <= 6'(w1.dst);
      read_addr[2] <= 6'($urandom_range(NUM_REGS - 1));
    end

    // retire by tag while a rename sometimes hits the same register
    for (int i = 0; i < 30; i++)
    begin
      @(negedge clk);
      k = 5'($urandom_range(NUM_REGS - 1));
      w0 = random_write(40);
      if ($urandom_range(1) == 0)
      begin
        w0.valid = 1'b1;
        w0.dst = k;
      end
      r0.valid = 1'b1;
      r0.tag = model[k].tag;
      r1.valid = 1'($urandom_range(1));
      r1.tag = `RAT_TAG_W'($urandom_range(15));
      clk_en <= 1'b1;
      writes[0] <= w0;
      writes[1] <= random_write(20);
      retires[0] <= r0;
      retires[1] <= r1;
      read_addr[0] <= 6'(k);
      read_addr[1] <= 6'(w0.dst);
      read_addr[2] <= 6'($urandom_range(NUM_REGS - 1));
    end

    for (int i = 0; i < 12; i++)
    begin
      @(negedge clk);
      w0 = random_write(90);
      retires <= '{default: '0};
      retire_all <= ($urandom_range(2) == 0);
      writes[0] <= w0;
      writes[1] <= random_write(50);
      read_addr[0] <= 6'(w0.dst);
      read_addr[1] <= 6'($urandom_range(NUM_REGS - 1));
      read_addr[2] <= 6'($urandom_range(NUM_REGS - 1));
    end

    // group slots, out-of-range slots and reserved addresses
    for (int i = 0; i < 30; i++)
    begin
      @(negedge clk);
      retire_all <= 1'b0;
      writes[0] <= random_write(50);
      writes[1] <= random_write(50);
      read_addr[0] <= 6'h30 | 6'($urandom_range(3));
      read_addr[1] <= 6'h30 | 6'($urandom_range(1));
      read_addr[2] <= 6'(32 + $urandom_range(31));
    end

    @(negedge clk);
    @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // twice the expected length of the run
  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d ns", 2 * TEST_CYCLES * CLK_PERIOD);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
